// ==== logic/bank_array.sv ====
`timescale 1ns/10ps

module bank_array
  import ddr3_protocol_pkg::*;
  import model_pkg::*;
#(
  parameter int BANK_INDEX = 0
)
(
  input  logic                  ck,
  input  logic                  reset_n,
  input  activate_t             activate,
  input  bank_access_t          wr_access,
  input  wr_beat_t              wr,
  input  bank_access_t          rd_access,
  output logic                  bank_valid,
  output logic [DATA_WIDTH-1:0] bank_data
);

  logic [ROW_WIDTH-1:0]  open_row;
  logic [DATA_WIDTH-1:0] mem [2**(ROW_WIDTH+COL_WIDTH)]; // row major
  logic                  act_hit;
  logic                  wr_hit;
  logic                  rd_hit;

  assign act_hit = activate.valid && (activate.bank == BA_WIDTH'(BANK_INDEX));
  assign wr_hit  = wr_access.valid && (wr_access.bank == BA_WIDTH'(BANK_INDEX));
  assign rd_hit  = rd_access.valid && (rd_access.bank == BA_WIDTH'(BANK_INDEX));

  always_ff @(posedge ck)
  begin
    if (!reset_n)
    begin
      open_row   <= '0;
      bank_valid <= 1'b0;
    end
    else
    begin
      if (act_hit)
        open_row <= activate.row;
      bank_valid <= rd_hit;
    end
  end

  // storage, byte lanes written only where the mask is low
  always_ff @(posedge ck)
  begin
    if (wr_hit)
      for (int b = 0; b < MASK_WIDTH; b++)
        if (!wr.mask[b])
          mem[{open_row, wr_access.col}][b*BYTE_WIDTH +: BYTE_WIDTH] <=
            wr.data[b*BYTE_WIDTH +: BYTE_WIDTH];
    if (rd_hit)
      bank_data <= mem[{open_row, rd_access.col}];
  end

endmodule

// ==== logic/burst_sequencer.sv ====
`timescale 1ns/10ps

module burst_sequencer
  import ddr3_protocol_pkg::*;
  import model_pkg::*;
(
  input  logic         ck,
  input  logic         reset_n,
  input  burst_cmd_t   start,
  output bank_access_t access
);

  typedef enum logic {
    IDLE,
    BURST
  } seq_state_e;

  seq_state_e            state;
  logic [BEAT_WIDTH-1:0] beat;      // index of the beat now on access
  logic                  long_q;
  logic [BEAT_WIDTH-1:0] burst_end;
  logic                  last_beat;
  logic                  accept;

  assign burst_end = long_q ? BEAT_WIDTH'(LONG_BURST - 1) : BEAT_WIDTH'(SHORT_BURST - 1);
  assign last_beat = (state == BURST) && (beat == burst_end);

  // a start mid-burst is dropped, on the last beat it chains on
  assign accept = start.valid && ((state == IDLE) || last_beat);

  always_ff @(posedge ck)
  begin
    if (!reset_n)
    begin
      state  <= IDLE;
      beat   <= '0;
      long_q <= 1'b0;
      access <= '0;
    end
    else if (accept)
    begin
      state  <= BURST;
      beat   <= '0;
      long_q <= start.long_burst;
      access <= '{valid: 1'b1, bank: start.bank, col: start.col};
    end
    else if (last_beat)
    begin
      state        <= IDLE;
      access.valid <= 1'b0;
    end
    else if (state == BURST)
    begin
      beat       <= beat + 1'b1;
      access.col <= access.col + 1'b1; // wraps at the column width
    end
  end

endmodule

// ==== logic/command_pipeline.sv ====
`timescale 1ns/10ps

module command_pipeline
  import ddr3_protocol_pkg::*;
  import model_pkg::*;
(
  input  logic       ck,
  input  logic       reset_n,
  input  mem_cmd_t   cmd,
  output activate_t  activate,
  output burst_cmd_t rd_cmd,
  output burst_cmd_t wr_cmd
);

  mem_cmd_t     cmd_q;
  ddr3_opcode_e opcode;
  burst_cmd_t   rd_in;
  burst_cmd_t   wr_in;

  // cmd_q is the first delay stage, so each line is one shorter
  burst_cmd_t rd_line [READ_DELAY-1];
  burst_cmd_t wr_line [WRITE_DELAY-1];

  always_ff @(posedge ck)
  begin
    if (!reset_n)
      cmd_q <= '{cs_n: 1'b1, ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1, default: '0};
    else
      cmd_q <= cmd;
  end

  always_comb
  begin
    if (cmd_q.cs_n)
      opcode = DES; // deselect regardless of the other strobes
    else
      opcode = ddr3_opcode_e'({cmd_q.cs_n, cmd_q.ras_n, cmd_q.cas_n, cmd_q.we_n});
  end

  // activate needs no delay
  assign activate = '{valid: (opcode == ACTIVATE), bank: cmd_q.ba,
                      row: cmd_q.a[ROW_WIDTH-1:0]};

  assign rd_in = '{valid: (opcode == READ), bank: cmd_q.ba,
                   col: cmd_q.a[COL_WIDTH-1:0], long_burst: cmd_q.a[BURST_BIT]};
  assign wr_in = '{valid: (opcode == WRITE), bank: cmd_q.ba,
                   col: cmd_q.a[COL_WIDTH-1:0], long_burst: cmd_q.a[BURST_BIT]};

  // plain shift lines, several commands may be in flight
  always_ff @(posedge ck)
  begin
    if (!reset_n)
    begin
      for (int i = 0; i < READ_DELAY - 1; i++)
        rd_line[i] <= '0;
      for (int i = 0; i < WRITE_DELAY - 1; i++)
        wr_line[i] <= '0;
    end
    else
    begin
      rd_line[0] <= rd_in;
      for (int i = 1; i < READ_DELAY - 1; i++)
        rd_line[i] <= rd_line[i-1];
      wr_line[0] <= wr_in;
      for (int i = 1; i < WRITE_DELAY - 1; i++)
        wr_line[i] <= wr_line[i-1];
    end
  end

  assign rd_cmd = rd_line[READ_DELAY-2];
  assign wr_cmd = wr_line[WRITE_DELAY-2];

endmodule

// ==== logic/ddr3_memory_model.sv ====
`timescale 1ns/10ps

module ddr3_memory_model
  import ddr3_protocol_pkg::*;
  import model_pkg::*;
(
  input  logic                  ck,
  input  logic                  reset_n,
  input  mem_cmd_t              cmd,
  input  wr_beat_t              wr,
  output logic                  rd_valid,
  output logic [DATA_WIDTH-1:0] rd_data
);

  activate_t                             activate;
  burst_cmd_t                            rd_cmd;
  burst_cmd_t                            wr_cmd;
  bank_access_t                          rd_access;
  bank_access_t                          wr_access;
  logic [BANK_COUNT-1:0]                 bank_valid;
  logic [BANK_COUNT-1:0][DATA_WIDTH-1:0] bank_data;

  command_pipeline pipeline (
    .ck       (ck),
    .reset_n  (reset_n),
    .cmd      (cmd),
    .activate (activate),
    .rd_cmd   (rd_cmd),
    .wr_cmd   (wr_cmd)
  );

  burst_sequencer rd_seq (
    .ck      (ck),
    .reset_n (reset_n),
    .start   (rd_cmd),
    .access  (rd_access)
  );

  burst_sequencer wr_seq (
    .ck      (ck),
    .reset_n (reset_n),
    .start   (wr_cmd),
    .access  (wr_access)
  );

  // every bank sees every access and picks its own
  for (genvar i = 0; i < BANK_COUNT; i++)
  begin : gen_bank
    bank_array #(
      .BANK_INDEX (i)
    ) bank (
      .ck         (ck),
      .reset_n    (reset_n),
      .activate   (activate),
      .wr_access  (wr_access),
      .wr         (wr),
      .rd_access  (rd_access),
      .bank_valid (bank_valid[i]),
      .bank_data  (bank_data[i])
    );
  end

  read_return ret (
    .ck         (ck),
    .reset_n    (reset_n),
    .bank_valid (bank_valid),
    .bank_data  (bank_data),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data)
  );

endmodule

// ==== logic/ddr3_protocol_pkg.sv ====
package ddr3_protocol_pkg;

  // pin widths
  localparam int ADDR_WIDTH = 13;
  localparam int BA_WIDTH   = 2;
  localparam int DATA_WIDTH = 16;
  localparam int MASK_WIDTH = 2;
  localparam int BYTE_WIDTH = DATA_WIDTH / MASK_WIDTH;

  localparam int BURST_BIT = 12; // a[12] high selects BL8, else BC4

  // latencies counted from the command edge
  localparam int READ_LATENCY  = 9; // CL 6 + AL 3
  localparam int WRITE_LATENCY = 8; // CWL 5 + AL 3

  localparam int SHORT_BURST = 4;
  localparam int LONG_BURST  = 8;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    MRS       = 4'b0000,
    REFRESH   = 4'b0001,
    PRECHARGE = 4'b0010,
    ACTIVATE  = 4'b0011,
    WRITE     = 4'b0100,
    READ      = 4'b0101,
    ZQC       = 4'b0110,
    NOP       = 4'b0111,
    DES       = 4'b1000  // any code with cs_n high
  } ddr3_opcode_e;

  // command and address pins, sampled every rising edge
  typedef struct packed {
    logic                  cs_n;
    logic                  ras_n;
    logic                  cas_n;
    logic                  we_n;
    logic [BA_WIDTH-1:0]   ba;
    logic [ADDR_WIDTH-1:0] a;
  } mem_cmd_t;

  // one write beat; mask bit high keeps that byte
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [MASK_WIDTH-1:0] mask;
  } wr_beat_t;

endpackage

// ==== logic/model_pkg.sv ====
package model_pkg;

  import ddr3_protocol_pkg::*;

  // geometry of the modelled device, kept small
  localparam int ROW_WIDTH  = 4;
  localparam int COL_WIDTH  = 6;
  localparam int BANK_COUNT = 4;

  localparam int BEAT_WIDTH = $clog2(LONG_BURST);

  // sequencer and bank stages take the remaining cycles
  localparam int READ_DELAY  = READ_LATENCY - 3;
  localparam int WRITE_DELAY = WRITE_LATENCY - 1;

  // delayed read or write, one per burst
  typedef struct packed {
    logic                 valid;
    logic [BA_WIDTH-1:0]  bank;
    logic [COL_WIDTH-1:0] col;
    logic                 long_burst;
  } burst_cmd_t;

  // single beat access to one bank
  typedef struct packed {
    logic                 valid;
    logic [BA_WIDTH-1:0]  bank;
    logic [COL_WIDTH-1:0] col;
  } bank_access_t;

  typedef struct packed {
    logic                 valid;
    logic [BA_WIDTH-1:0]  bank;
    logic [ROW_WIDTH-1:0] row;
  } activate_t;

endpackage

// ==== logic/read_return.sv ====
`timescale 1ns/10ps

module read_return
  import ddr3_protocol_pkg::*;
  import model_pkg::*;
(
  input  logic                                  ck,
  input  logic                                  reset_n,
  input  logic [BANK_COUNT-1:0]                 bank_valid,
  input  logic [BANK_COUNT-1:0][DATA_WIDTH-1:0] bank_data,
  output logic                                  rd_valid,
  output logic [DATA_WIDTH-1:0]                 rd_data
);

  logic [DATA_WIDTH-1:0] sel_data;

  // at most one bank answers in a cycle
  always_comb
  begin
    sel_data = '0;
    for (int i = 0; i < BANK_COUNT; i++)
      if (bank_valid[i])
        sel_data = bank_data[i];
  end

  always_ff @(posedge ck)
  begin
    if (!reset_n)
      rd_valid <= 1'b0;
    else
      rd_valid <= |bank_valid;
  end

  always_ff @(posedge ck)
  begin
    rd_data <= sel_data; // don't care while rd_valid is low
  end

endmodule

// ==== project.f ====
logic/ddr3_protocol_pkg.sv
logic/model_pkg.sv
logic/command_pipeline.sv
logic/burst_sequencer.sv
logic/bank_array.sv
logic/read_return.sv
logic/ddr3_memory_model.sv
tb/ddr3_memory_model_properties.sv
tb/ddr3_memory_model_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the DDR3 model testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
  --top-module ddr3_memory_model_tb -o sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tb/ddr3_memory_model_properties.sv ====
`timescale 1ns/10ps

module ddr3_memory_model_properties
  import ddr3_protocol_pkg::*;
(
  input logic                  ck,
  input logic                  reset_n,
  input logic                  rd_valid,
  input logic [DATA_WIDTH-1:0] rd_data,
  input logic                  rd_start_mid,  // start seen inside a burst, not on its last beat
  input logic                  wr_start_mid
);

  logic [3:0] run_len; // rd_valid cycles so far in the current run
  int         fail_count = 0;

  always_ff @(posedge ck)
  begin
    if (!reset_n)
      run_len <= '0;
    else if (rd_valid)
      run_len <= run_len + 4'd1;
    else
      run_len <= '0;
  end

  // a run is one BC4/BL8 burst or two chained BC4 bursts
  rd_valid_too_long: assert property (@(posedge ck) disable iff (!reset_n)
    rd_valid |-> (run_len < 4'(LONG_BURST)))
    else
    begin
      $error("rd_valid run longer than 8 cycles");
      fail_count++;
    end

  rd_valid_run_end: assert property (@(posedge ck) disable iff (!reset_n)
    $fell(rd_valid) |-> (run_len == 4'(SHORT_BURST) || run_len == 4'(LONG_BURST)))
    else
    begin
      $error("rd_valid run is not 4 or 8 cycles long");
      fail_count++;
    end

  rd_data_known: assert property (@(posedge ck) disable iff (!reset_n)
    rd_valid |-> !$isunknown(rd_data))
    else
    begin
      $error("rd_data unknown during a read beat");
      fail_count++;
    end

  rd_spacing: assert property (@(posedge ck) disable iff (!reset_n) !rd_start_mid)
    else
    begin
      $error("read command arrived inside a running burst");
      fail_count++;
    end

  wr_spacing: assert property (@(posedge ck) disable iff (!reset_n) !wr_start_mid)
    else
    begin
      $error("write command arrived inside a running burst");
      fail_count++;
    end

endmodule

bind ddr3_memory_model ddr3_memory_model_properties props (
  .ck           (ck),
  .reset_n      (reset_n),
  .rd_valid     (rd_valid),
  .rd_data      (rd_data),
  .rd_start_mid (rd_seq.start.valid && (rd_seq.state == 1'b1) && !rd_seq.last_beat),
  .wr_start_mid (wr_seq.start.valid && (wr_seq.state == 1'b1) && !wr_seq.last_beat)
);

// ==== tb/ddr3_memory_model_tb.sv ====
`timescale 1ns/10ps

module ddr3_memory_model_tb
  import ddr3_protocol_pkg::*;
  import model_pkg::*;
;

  typedef enum logic [1:0] {
    OP_ACT,
    OP_WR,
    OP_RD,
    OP_RD2  // two reads one burst apart
  } step_op_e;

  typedef struct packed {
    step_op_e             op;
    logic [BA_WIDTH-1:0]  bank;
    logic [ROW_WIDTH-1:0] row;
    logic [COL_WIDTH-1:0] col;
    logic                 long_burst;
    logic [MASK_WIDTH-1:0] mask;
    logic [3:0]           test_id;
  } step_t;

  localparam int STEPS = 23;
  localparam int TIMEOUT_NS = (10 + 40 * STEPS + 100) * 100;
  localparam mem_cmd_t NOP_CMD = mem_cmd_t'({NOP, {BA_WIDTH{1'b0}}, {ADDR_WIDTH{1'b0}}});

  logic                  ck;
  logic                  reset_n;
  mem_cmd_t              cmd;
  wr_beat_t              wr;
  logic                  rd_valid;
  logic [DATA_WIDTH-1:0] rd_data;

  step_t                 steps [STEPS];
  logic [DATA_WIDTH-1:0] shadow [BANK_COUNT][2**ROW_WIDTH][2**COL_WIDTH];
  logic [ROW_WIDTH-1:0]  open_row [BANK_COUNT];
  integer                seed;
  int                    errors;
  int                    test_errors;
  int                    tests_done;

  ddr3_memory_model DUT (
    .ck       (ck),
    .reset_n  (reset_n),
    .cmd      (cmd),
    .wr       (wr),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

  initial
  begin
    ck = 1'b0;
    forever #50 ck = ~ck;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog expired, the tests did not finish in time");
    $display("Regression failed");
    $finish;
  end

  function automatic mem_cmd_t make_cmd(input ddr3_opcode_e op, input logic [BA_WIDTH-1:0] ba,
                                        input logic [COL_WIDTH-1:0] col, input logic long_burst);
    logic [ADDR_WIDTH-1:0] a;
    a = '0;
    a[COL_WIDTH-1:0] = col;
    a[BURST_BIT] = long_burst;
    return mem_cmd_t'({op, ba, a});
  endfunction

  task automatic report_mismatch(input string name, input logic [DATA_WIDTH-1:0] expected,
                                 input logic [DATA_WIDTH-1:0] actual);
    $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
    errors++;
    test_errors++;
  endtask

  task automatic do_activate(input logic [BA_WIDTH-1:0] bank, input logic [ROW_WIDTH-1:0] row);
    @(posedge ck);
    cmd <= make_cmd(ACTIVATE, bank, COL_WIDTH'(row), 1'b0); // row rides on the low address bits
    @(posedge ck);
    cmd <= NOP_CMD;
    open_row[bank] = row;
  endtask

  task automatic do_write(input step_t s);
    int                    n;
    logic [DATA_WIDTH-1:0] d;
    logic [COL_WIDTH-1:0]  c;
    n = s.long_burst ? LONG_BURST : SHORT_BURST;
    @(posedge ck);
    cmd <= make_cmd(WRITE, s.bank, s.col, s.long_burst);
    @(posedge ck);
    cmd <= NOP_CMD;
    repeat (WRITE_LATENCY - 1) @(posedge ck); // beat 0 lands on the k+8 edge
    for (int b = 0; b < n; b++)
    begin
      if (b > 0)
        @(posedge ck);
      d = DATA_WIDTH'($random(seed));
      c = s.col + COL_WIDTH'(b); // wraps like the device
      wr <= '{data: d, mask: s.mask};
      for (int m = 0; m < MASK_WIDTH; m++)
        if (!s.mask[m])
          shadow[s.bank][open_row[s.bank]][c][m*BYTE_WIDTH +: BYTE_WIDTH] =
            d[m*BYTE_WIDTH +: BYTE_WIDTH];
    end
  endtask

  task automatic do_read(input step_t s, input logic twice);
    int                    n;
    int                    total;
    int                    waited;
    logic                  found;
    logic [COL_WIDTH-1:0]  c;
    logic [DATA_WIDTH-1:0] expected;
    n = s.long_burst ? LONG_BURST : SHORT_BURST;
    total = twice ? 2 * n : n;
    found = 1'b0;
    @(posedge ck);
    cmd <= make_cmd(READ, s.bank, s.col, s.long_burst);
    @(posedge ck);
    cmd <= NOP_CMD;
    waited = 0;
    if (twice)
    begin
      repeat (n - 1) @(posedge ck);
      cmd <= make_cmd(READ, s.bank, s.col + COL_WIDTH'(n), s.long_burst);
      @(posedge ck);
      cmd <= NOP_CMD;
      waited = n; // cycles already spent since the first command edge
    end
    while (!found && waited < 30)
    begin
      @(negedge ck);
      waited++;
      if (rd_valid)
        found = 1'b1;
    end
    if (!found)
    begin
      $display("read from bank %0d col %0d never returned data", s.bank, s.col);
      errors++;
      test_errors++;
      return;
    end
    if (waited != READ_LATENCY)
      report_mismatch("read latency", DATA_WIDTH'(READ_LATENCY), DATA_WIDTH'(waited));
    for (int b = 0; b < total; b++)
    begin
      if (b > 0)
        @(negedge ck);
      c = s.col + COL_WIDTH'(b);
      expected = shadow[s.bank][open_row[s.bank]][c];
      if (rd_valid !== 1'b1)
        report_mismatch("rd_valid", DATA_WIDTH'(1), DATA_WIDTH'(rd_valid));
      if (rd_data !== expected)
        report_mismatch("rd_data", expected, rd_data);
    end
    @(negedge ck);
    if (rd_valid !== 1'b0)
      report_mismatch("rd_valid", DATA_WIDTH'(0), DATA_WIDTH'(rd_valid));
  endtask

  // op, bank, row, col, long, mask, test
  task automatic load_steps();
    steps[0]  = '{OP_ACT, 2'd0, 4'd3, 6'd0,  1'b0, 2'b00, 4'd1};
    steps[1]  = '{OP_WR,  2'd0, 4'd0, 6'd4,  1'b0, 2'b00, 4'd1};
    steps[2]  = '{OP_RD,  2'd0, 4'd0, 6'd4,  1'b0, 2'b00, 4'd1};
    steps[3]  = '{OP_ACT, 2'd1, 4'd5, 6'd0,  1'b0, 2'b00, 4'd2};
    steps[4]  = '{OP_WR,  2'd1, 4'd0, 6'd8,  1'b1, 2'b00, 4'd2};
    steps[5]  = '{OP_RD,  2'd1, 4'd0, 6'd8,  1'b1, 2'b00, 4'd2};
    steps[6]  = '{OP_WR,  2'd0, 4'd0, 6'd4,  1'b0, 2'b01, 4'd3};
    steps[7]  = '{OP_RD,  2'd0, 4'd0, 6'd4,  1'b0, 2'b00, 4'd3};
    steps[8]  = '{OP_WR,  2'd0, 4'd0, 6'd4,  1'b0, 2'b10, 4'd3};
    steps[9]  = '{OP_RD,  2'd0, 4'd0, 6'd4,  1'b0, 2'b00, 4'd3};
    steps[10] = '{OP_ACT, 2'd2, 4'd7, 6'd0,  1'b0, 2'b00, 4'd4};
    steps[11] = '{OP_WR,  2'd2, 4'd0, 6'd4,  1'b0, 2'b00, 4'd4};
    steps[12] = '{OP_RD,  2'd0, 4'd0, 6'd4,  1'b0, 2'b00, 4'd4};
    steps[13] = '{OP_RD,  2'd2, 4'd0, 6'd4,  1'b0, 2'b00, 4'd4};
    steps[14] = '{OP_ACT, 2'd2, 4'd9, 6'd0,  1'b0, 2'b00, 4'd4};
    steps[15] = '{OP_WR,  2'd2, 4'd0, 6'd4,  1'b0, 2'b00, 4'd4};
    steps[16] = '{OP_RD,  2'd2, 4'd0, 6'd4,  1'b0, 2'b00, 4'd4};
    steps[17] = '{OP_ACT, 2'd2, 4'd7, 6'd0,  1'b0, 2'b00, 4'd4};
    steps[18] = '{OP_RD,  2'd2, 4'd0, 6'd4,  1'b0, 2'b00, 4'd4};
    steps[19] = '{OP_ACT, 2'd3, 4'd1, 6'd0,  1'b0, 2'b00, 4'd5};
    steps[20] = '{OP_WR,  2'd3, 4'd0, 6'd62, 1'b1, 2'b00, 4'd5};
    steps[21] = '{OP_RD,  2'd3, 4'd0, 6'd62, 1'b1, 2'b00, 4'd5};
    steps[22] = '{OP_RD2, 2'd1, 4'd0, 6'd8,  1'b0, 2'b00, 4'd6};
  endtask

  initial
  begin
    seed = 38;
    errors = 0;
    test_errors = 0;
    tests_done = 0;
    cmd = NOP_CMD;
    wr = '0;
    reset_n = 1'b0;
    load_steps();
    repeat (10) @(posedge ck);
    reset_n <= 1'b1;
    @(negedge ck);
    if (rd_valid !== 1'b0)
      report_mismatch("rd_valid", DATA_WIDTH'(0), DATA_WIDTH'(rd_valid));
    for (int s = 0; s < STEPS; s++)
    begin
      case (steps[s].op)
        OP_ACT:  do_activate(steps[s].bank, steps[s].row);
        OP_WR:   do_write(steps[s]);
        OP_RD:   do_read(steps[s], 1'b0);
        default: do_read(steps[s], 1'b1);
      endcase
      if (s == STEPS - 1 || steps[s+1].test_id != steps[s].test_id)
      begin
        $display("test %0d done with %0d errors", steps[s].test_id, test_errors);
        tests_done++;
        test_errors = 0;
      end
    end
    $display("%0d tests run, %0d errors, %0d assertion failures", tests_done, errors,
             DUT.props.fail_count);
    if (errors == 0 && DUT.props.fail_count == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule
